/* fm_pkg.sv */
// FM operator phase path definitions
package fm_pkg;

    localparam int REG_FNUM_WIDTH  = 10; // f-number field, ten bits as on the OPL3.
    localparam int REG_BLOCK_WIDTH = 3;  // block selects the octave.
    localparam int REG_MULT_WIDTH  = 4;  // multiplier code indexes the ratio table.
    localparam int PHASE_ACC_WIDTH = 20; // phase step and phase share this width.
    localparam int REG_DATA_WIDTH  = 8;  // the host writes one byte at a time.
    localparam int REG_ADDR_WIDTH  = 2;  // four register addresses per operator.

    typedef logic [REG_FNUM_WIDTH-1:0]  fnum_t;     // raw f-number.
    typedef logic [REG_BLOCK_WIDTH-1:0] block_t;    // octave shift amount.
    typedef logic [REG_MULT_WIDTH-1:0]  mult_t;     // frequency multiplier code.
    typedef logic [PHASE_ACC_WIDTH-1:0] phase_t;    // phase step or phase value.
    typedef logic [REG_DATA_WIDTH-1:0]  reg_data_t; // host write data.
    typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t; // host write address.

    // Register map of the single operator.
    localparam reg_addr_t ADDR_FNUM_LO   = 2'd0; // f-number bits 7..0.
    localparam reg_addr_t ADDR_KEY_BLOCK = 2'd1; // key-on, block and f-number bits 9..8.
    localparam reg_addr_t ADDR_VIB_MULT  = 2'd2; // vibrato enable and multiplier.
    localparam reg_addr_t ADDR_DEPTH     = 2'd3; // deep vibrato select.

endpackage

/* op_freq_if.sv */
// Operator frequency field bundle
`timescale 1ns/1ns

interface op_freq_if;

    fm_pkg::fnum_t  fnum;   // f-number, sets the base pitch.
    fm_pkg::block_t block;  // octave, shifts the f-number left.
    fm_pkg::mult_t  mult;   // ratio code for the multiplier table.
    logic           vib;    // adds the vibrato deviation when set.
    logic           dvb;    // deep vibrato, otherwise the deviation is halved.
    logic           key_on; // a rising edge restarts the phase.

    // The register block owns every field.
    modport regs (
        output fnum,
        output block,
        output mult,
        output vib,
        output dvb,
        output key_on
    );

    // The phase path only reads the fields.
    modport phase (
        input fnum,
        input block,
        input mult,
        input vib,
        input dvb,
        input key_on
    );

endinterface

/* op_freq_regs.sv */
// Operator frequency registers
`timescale 1ns/1ns

module op_freq_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,   // one-cycle host write strobe.
    input  fm_pkg::reg_addr_t wr_addr, // selects one of four registers.
    input  fm_pkg::reg_data_t wr_data, // byte that holds the new fields.
    op_freq_if.regs           freq     // fields to the phase path.
);

    fm_pkg::fnum_t  fnum_q;   // f-number built from two writes.
    fm_pkg::block_t block_q;  // octave field.
    fm_pkg::mult_t  mult_q;   // multiplier code.
    logic           vib_q;    // vibrato enable.
    logic           dvb_q;    // deep vibrato select.
    logic           key_on_q; // key-on as written by the host.

    // Each write updates only the fields of its own address.
    // Bits that carry no field are ignored.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fnum_q   <= '0;   // silent operator after reset.
            block_q  <= '0;
            mult_q   <= '0;
            vib_q    <= 1'b0;
            dvb_q    <= 1'b0;
            key_on_q <= 1'b0; // key released so the first key-on is an edge.
        end else if (wr_en) begin
            case (wr_addr)
                fm_pkg::ADDR_FNUM_LO: begin
                    fnum_q[7:0] <= wr_data;             // low f-number byte.
                end
                fm_pkg::ADDR_KEY_BLOCK: begin
                    key_on_q    <= wr_data[5];          // key-on lives in bit 5.
                    block_q     <= wr_data[4:2];        // octave in bits 4..2.
                    fnum_q[9:8] <= wr_data[1:0];        // top f-number bits.
                end
                fm_pkg::ADDR_VIB_MULT: begin
                    vib_q  <= wr_data[4];               // vibrato enable.
                    mult_q <= wr_data[3:0];             // ratio code.
                end
                fm_pkg::ADDR_DEPTH: begin
                    dvb_q <= wr_data[0];                // only bit 0 is used.
                end
            endcase
        end
    end

    // Held values go straight onto the bundle.
    assign freq.fnum   = fnum_q;
    assign freq.block  = block_q;
    assign freq.mult   = mult_q;
    assign freq.vib    = vib_q;
    assign freq.dvb    = dvb_q;
    assign freq.key_on = key_on_q;

endmodule

/* sample_strobe_gen.sv */
// Sample rate strobe generator
`timescale 1ns/1ns

module sample_strobe_gen #(
    parameter int SAMPLE_DIV = 4 // system clocks per sample.
) (
    input  logic clk,
    input  logic rst_n,
    output logic sample_en       // one-cycle pulse per sample.
);

    // A divide by one still needs a one-bit counter.
    localparam int CNT_WIDTH = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
    localparam logic [CNT_WIDTH-1:0] CNT_LOAD = CNT_WIDTH'(SAMPLE_DIV - 1);

    logic [CNT_WIDTH-1:0] cnt; // cycles left until the next pulse.

    // The counter runs down to zero, then reloads and fires.
    // So the first pulse lands SAMPLE_DIV cycles after reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= CNT_LOAD; // full period before the first pulse.
            sample_en <= 1'b0;
        end else if (cnt == '0) begin
            cnt       <= CNT_LOAD; // wrap and start a new period.
            sample_en <= 1'b1;     // exactly one pulse per wrap.
        end else begin
            cnt       <= cnt - 1'b1;
            sample_en <= 1'b0;
        end
    end

endmodule

/* calc_phase_inc.sv */
// Phase step with multiplier and vibrato
`timescale 1ns/1ns

module calc_phase_inc #(
    parameter int VIB_INDEX_WIDTH = 13 // LFO counter width, sets the vibrato rate.
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          sample_en,   // advances the vibrato LFO.
    op_freq_if.phase      freq,        // frequency fields from the registers.
    output fm_pkg::phase_t phase_inc   // per-sample phase step.
);

    fm_pkg::phase_t pre_mult;     // f-number after the octave shift.
    fm_pkg::phase_t post_mult;    // shifted f-number scaled by the ratio.
    fm_pkg::phase_t phase_inc_p0; // extra stage after the multiply.

    logic [VIB_INDEX_WIDTH-1:0] vib_index; // free-running LFO count.
    logic [2:0]                 vib_phase; // eight vibrato steps per LFO period.

    fm_pkg::fnum_t delta0; // raw deviation from the upper f-number bits.
    fm_pkg::fnum_t delta1; // after the shallow-step halving.
    fm_pkg::fnum_t delta2; // after the depth halving.
    fm_pkg::fnum_t delta3; // registered and signed by inversion.

    // Stage one widens the f-number before shifting so no octave bits are lost.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_mult <= '0;
        end else begin
            pre_mult <= fm_pkg::phase_t'(freq.fnum) << freq.block;
        end
    end

    // Stage two applies the OPL3 ratio table.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            post_mult <= '0;
        end else begin
            case (freq.mult)
                4'h0: post_mult <= pre_mult >> 1; // code 0 is half the base rate.
                4'h1: post_mult <= pre_mult;
                4'h2: post_mult <= fm_pkg::phase_t'(pre_mult * 2);
                4'h3: post_mult <= fm_pkg::phase_t'(pre_mult * 3);
                4'h4: post_mult <= fm_pkg::phase_t'(pre_mult * 4);
                4'h5: post_mult <= fm_pkg::phase_t'(pre_mult * 5);
                4'h6: post_mult <= fm_pkg::phase_t'(pre_mult * 6);
                4'h7: post_mult <= fm_pkg::phase_t'(pre_mult * 7);
                4'h8: post_mult <= fm_pkg::phase_t'(pre_mult * 8);
                4'h9: post_mult <= fm_pkg::phase_t'(pre_mult * 9);
                4'hA: post_mult <= fm_pkg::phase_t'(pre_mult * 10);
                4'hB: post_mult <= fm_pkg::phase_t'(pre_mult * 10); // repeats 10.
                4'hC: post_mult <= fm_pkg::phase_t'(pre_mult * 12);
                4'hD: post_mult <= fm_pkg::phase_t'(pre_mult * 12); // repeats 12.
                4'hE: post_mult <= fm_pkg::phase_t'(pre_mult * 15);
                default: post_mult <= fm_pkg::phase_t'(pre_mult * 15); // code F.
            endcase
        end
    end

    // Stage three only breaks up the multiplier path.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_inc_p0 <= '0;
        end else begin
            phase_inc_p0 <= post_mult;
        end
    end

    // Stage four adds the deviation while vibrato is on.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_inc <= '0;
        end else if (freq.vib) begin
            phase_inc <= phase_inc_p0 + fm_pkg::phase_t'(delta3); // deviation is zero-extended.
        end else begin
            phase_inc <= phase_inc_p0;
        end
    end

    // The LFO moves one count per sample.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vib_index <= '0;
        end else if (sample_en) begin
            vib_index <= vib_index + 1'b1; // wraps freely.
        end
    end

    assign vib_phase = vib_index[VIB_INDEX_WIDTH-1 -: 3]; // top three bits pick the step.

    // Deviation scales with pitch through the upper f-number bits.
    always_comb begin
        delta0 = freq.fnum >> 7;
        delta1 = (vib_phase[1:0] == 2'b11) ? (delta0 >> 1) : delta0; // shallow step.
        delta2 = freq.dvb ? delta1 : (delta1 >> 1);                  // shallow depth.
    end

    // The second half of the LFO period inverts the deviation.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            delta3 <= '0;
        end else begin
            delta3 <= vib_phase[2] ? ~delta2 : delta2;
        end
    end

endmodule

/* phase_acc.sv */
// Operator phase accumulator
`timescale 1ns/1ns

module phase_acc (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sample_en, // one step per sample.
    input  fm_pkg::phase_t phase_inc, // step from the increment block.
    op_freq_if.phase       freq,      // only key_on is used here.
    output fm_pkg::phase_t phase      // current operator phase.
);

    logic key_on_q; // key_on one cycle ago.
    logic key_rise; // key_on has just gone high.

    // Edge detect on the host key-on bit.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_on_q <= 1'b0;
        end else begin
            key_on_q <= freq.key_on;
        end
    end

    assign key_rise = freq.key_on & ~key_on_q; // high for one cycle per key press.

    // A new note starts from phase zero.
    // Otherwise the NCO adds the step on each sample and wraps naturally.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (key_rise) begin
            phase <= '0;                  // restart wins over a coincident sample.
        end else if (sample_en) begin
            phase <= phase + phase_inc;   // modulo 2**20 by width.
        end
    end

endmodule

/* fm_phase_top.sv */
// FM operator phase path top level
`timescale 1ns/1ns

module fm_phase_top #(
    parameter int SAMPLE_DIV      = 4,  // system clocks per sample.
    parameter int VIB_INDEX_WIDTH = 13  // LFO counter width.
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,     // host write strobe.
    input  fm_pkg::reg_addr_t wr_addr,   // host register address.
    input  fm_pkg::reg_data_t wr_data,   // host register data.
    output fm_pkg::phase_t    phase_inc, // per-sample phase step.
    output fm_pkg::phase_t    phase,     // accumulated phase.
    output logic              sample_en  // sample-rate strobe.
);

    op_freq_if u_freq (); // frequency fields shared by the phase path.

    // Host side register file.
    op_freq_regs u_op_freq_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .freq    (u_freq.regs)
    );

    // Sample clock enable.
    sample_strobe_gen #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_sample_strobe_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en)
    );

    // Step calculation with vibrato.
    calc_phase_inc #(
        .VIB_INDEX_WIDTH (VIB_INDEX_WIDTH)
    ) u_calc_phase_inc (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .freq      (u_freq.phase),
        .phase_inc (phase_inc)
    );

    // The NCO itself.
    phase_acc u_phase_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .phase_inc (phase_inc),
        .freq      (u_freq.phase),
        .phase     (phase)
    );

endmodule

/* tb_fm_phase.sv */
// FM phase path testbench
`timescale 1ns/1ns

module tb_fm_phase;

    localparam int SAMPLE_DIV  = 2;  // fast sample rate keeps the LFO sweep short.
    localparam int VIB_W       = 13; // LFO counter width, the DUT default.
    localparam int NUM_TRIALS  = 60; // random multiplier trials.
    localparam int ACC_ROUNDS  = 3;  // key-on restarts in the accumulation test.
    localparam int ACC_SAMPLES = 40; // samples summed after each restart.
    localparam int LFO_PERIOD_CYCLES = (1 << VIB_W) * SAMPLE_DIV; // one full vibrato cycle.
    // the sweep takes 16.4k cycles and everything else well under 1k, so 20k leaves margin.
    localparam int TIMEOUT_CYCLES = 20000;
    // twice the ratio of each multiplier code, so code 0 becomes a plain half.
    localparam logic [79:0] MULT_X2 = {5'd30, 5'd30, 5'd24, 5'd24, 5'd20, 5'd20, 5'd18,
                                       5'd16, 5'd14, 5'd12, 5'd10, 5'd8, 5'd6, 5'd4,
                                       5'd2, 5'd1};

    logic              clk;
    logic              rst_n;
    logic              wr_en;
    fm_pkg::reg_addr_t wr_addr;
    fm_pkg::reg_data_t wr_data;
    fm_pkg::phase_t    phase_inc;
    fm_pkg::phase_t    phase;
    logic              sample_en;

    logic [31:0]         rng_state = 32'd71462; // fixed seed so every run is the same.
    int                  cycle_count = 0;       // cycles since time zero.
    logic [7:0]          vib_seen;              // LFO steps met while vibrato was checked.

    // Reference model state, one value per DUT cycle.
    fm_pkg::fnum_t       m_fnum;
    fm_pkg::block_t      m_block;
    fm_pkg::mult_t       m_mult;
    logic                m_vib;
    logic                m_dvb;
    logic                m_key;
    logic                m_key_q;                // key-on one cycle later, for the edge.
    int                  m_cnt;                  // cycles left to the next sample.
    logic                m_sample_en;
    logic [VIB_W-1:0]    m_lfo;                  // samples counted since reset.
    logic [VIB_W-1:0]    m_lfo_d1;
    logic [VIB_W-1:0]    m_lfo_d2;               // the count that phase_inc reflects now.
    int                  m_since;                // cycles since a step field changed.
    fm_pkg::phase_t      m_inc;                  // predicted phase_inc.
    logic                m_inc_known = 1'b0;     // fields settled through the pipeline.
    fm_pkg::phase_t      m_phase;                // model phase sum.
    logic                m_phase_known = 1'b0;   // every added step was a known one.

    fm_phase_top #(
        .SAMPLE_DIV      (SAMPLE_DIV),
        .VIB_INDEX_WIDTH (VIB_W)
    ) u_fm_phase_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .phase_inc (phase_inc),
        .phase     (phase),
        .sample_en (sample_en)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223; // full-period 32-bit LCG.
    endfunction

    // Phase step from the OPL3 rules: octave shift, ratio, then the vibrato deviation.
    function automatic fm_pkg::phase_t predict_inc(input fm_pkg::fnum_t fnum,
                                                   input fm_pkg::block_t block,
                                                   input fm_pkg::mult_t mult,
                                                   input logic vib,
                                                   input logic dvb,
                                                   input logic [VIB_W-1:0] lfo);
        logic [31:0]   base;
        logic [2:0]    vib_step;
        fm_pkg::fnum_t dev;
        base = 32'(fnum) << block;
        base = (base * MULT_X2[mult*5 +: 5]) >> 1;   // half ratios need the extra bit.
        vib_step = lfo[VIB_W-1 -: 3];                 // eight steps per LFO period.
        dev = fnum >> 7;
        if (vib_step[1:0] == 2'b11) dev = dev >> 1;   // shallow step of the triangle.
        if (!dvb) dev = dev >> 1;                     // normal depth is half of deep.
        if (vib_step[2]) dev = ~dev;                  // falling half of the LFO.
        if (vib) base = base + 32'(dev);
        return fm_pkg::phase_t'(base);                // wraps at 20 bits.
    endfunction

    task automatic stop_on_failure();
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_phase_inc(input fm_pkg::phase_t expected);
        if (phase_inc !== expected) begin
            $display("[ERROR] time %0t: phase_inc expected %05h, actual %05h",
                     $time, expected, phase_inc);
            stop_on_failure();
        end
    endtask

    task automatic check_phase(input fm_pkg::phase_t expected);
        if (phase !== expected) begin
            $display("[ERROR] time %0t: phase expected %05h, actual %05h",
                     $time, expected, phase);
            stop_on_failure();
        end
    endtask

    task automatic check_sample_en(input logic expected);
        if (sample_en !== expected) begin
            $display("[ERROR] time %0t: sample_en expected %b, actual %b",
                     $time, expected, sample_en);
            stop_on_failure();
        end
    endtask

    // Waits for the next edge, moves the model by one cycle and compares all outputs.
    task automatic step();
        logic        key_rise;
        logic [18:0] old_fields;
        @(posedge clk);
        #10; // outputs are settled and the inputs of the past cycle are still held.
        if (!rst_n) begin
            {m_fnum, m_block, m_mult, m_vib, m_dvb, m_key, m_key_q} = '0;
            m_cnt = SAMPLE_DIV - 1;                   // first pulse one full period out.
            m_sample_en = 1'b0;
            {m_lfo, m_lfo_d1, m_lfo_d2} = '0;
            m_since = 4;                              // zero fields give a zero step.
            m_phase = '0;
            m_phase_known = 1'b1;
        end else begin
            key_rise = m_key & ~m_key_q;
            m_key_q = m_key;
            if (key_rise) begin
                m_phase = '0;                         // a new note starts at zero.
                m_phase_known = 1'b1;
            end else if (m_sample_en) begin
                if (m_inc_known) m_phase = m_phase + m_inc;
                else m_phase_known = 1'b0;            // the step was in transit.
            end
            m_lfo_d2 = m_lfo_d1;
            m_lfo_d1 = m_lfo;
            if (m_sample_en) m_lfo = m_lfo + 1'b1;
            if (m_cnt == 0) begin
                m_cnt = SAMPLE_DIV - 1;
                m_sample_en = 1'b1;
            end else begin
                m_cnt = m_cnt - 1;
                m_sample_en = 1'b0;
            end
            old_fields = {m_fnum, m_block, m_mult, m_vib, m_dvb};
            if (wr_en) begin
                case (wr_addr)
                    fm_pkg::ADDR_FNUM_LO:   m_fnum[7:0] = wr_data;
                    fm_pkg::ADDR_KEY_BLOCK: {m_key, m_block, m_fnum[9:8]} = wr_data[5:0];
                    fm_pkg::ADDR_VIB_MULT:  {m_vib, m_mult} = wr_data[4:0];
                    default:                m_dvb = wr_data[0];
                endcase
            end
            if (old_fields != {m_fnum, m_block, m_mult, m_vib, m_dvb}) m_since = 0;
            else if (m_since < 4) m_since++;
        end
        m_inc = predict_inc(m_fnum, m_block, m_mult, m_vib, m_dvb, m_lfo_d2);
        m_inc_known = (m_since >= 4);                 // four stages hold the old fields.
        check_sample_en(m_sample_en);
        if (m_inc_known) check_phase_inc(m_inc);
        if (m_inc_known && m_vib) vib_seen[m_lfo_d2[VIB_W-1 -: 3]] = 1'b1;
        if (m_phase_known) check_phase(m_phase);
    endtask

    // One-cycle host write strobe.
    task automatic write_reg(input fm_pkg::reg_addr_t addr, input fm_pkg::reg_data_t data);
        wr_en = 1'b1;
        wr_addr = addr;
        wr_data = data;
        step();
        wr_en = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    initial begin
        fm_pkg::fnum_t  fnum;
        fm_pkg::block_t block;
        fm_pkg::mult_t  mult;
        logic [31:0]    r;
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (5) step();                            // reset held for five cycles.
        rst_n = 1'b1;
        step();
        check_phase_inc('0);                          // everything starts from zero.
        check_phase('0);
        check_sample_en(1'b0);

        // Ratio table with vibrato off, junk in the unused data bits.
        for (int i = 0; i < NUM_TRIALS; i++) begin
            rng_state = lcg_next(rng_state);
            r = rng_state;
            fnum = r[31:22];
            block = r[21:19];
            mult = (i < 16) ? fm_pkg::mult_t'(i) : r[18:15]; // every code at least once.
            write_reg(fm_pkg::ADDR_VIB_MULT, {r[14:12], 1'b0, mult});
            write_reg(fm_pkg::ADDR_FNUM_LO, fnum[7:0]);
            write_reg(fm_pkg::ADDR_KEY_BLOCK, {r[11:10], 1'b0, block, fnum[9:8]});
            repeat (4) step();                        // five cycles after the last write.
            check_phase_inc(predict_inc(fnum, block, mult, 1'b0, m_dvb, m_lfo_d2));
        end

        // Vibrato over one whole LFO period, top f-number bits set for a large swing.
        rng_state = lcg_next(rng_state);
        r = rng_state;
        write_reg(fm_pkg::ADDR_FNUM_LO, r[31:24]);
        write_reg(fm_pkg::ADDR_KEY_BLOCK, {3'b000, r[23:21], 2'b11});
        write_reg(fm_pkg::ADDR_VIB_MULT, {3'b000, 1'b1, r[20:17]});
        write_reg(fm_pkg::ADDR_DEPTH, {7'd0, r[16]});
        vib_seen = '0;
        repeat (LFO_PERIOD_CYCLES + 8) step();        // step() compares every cycle.
        if (vib_seen != 8'hFF) begin
            $display("the vibrato sweep did not reach all eight LFO steps");
            stop_on_failure();
        end

        // Accumulation from a key-on restart.
        for (int n = 0; n < ACC_ROUNDS; n++) begin
            rng_state = lcg_next(rng_state);
            r = rng_state;
            write_reg(fm_pkg::ADDR_VIB_MULT, {3'b000, r[5], r[4:1]});
            write_reg(fm_pkg::ADDR_FNUM_LO, r[31:24]);
            write_reg(fm_pkg::ADDR_KEY_BLOCK, {3'b000, r[23:21], r[20:19]}); // key off.
            repeat (6) step();
            write_reg(fm_pkg::ADDR_KEY_BLOCK, {3'b001, r[23:21], r[20:19]}); // key on.
            step();
            check_phase('0);                          // restart one cycle after the field.
            repeat (ACC_SAMPLES * SAMPLE_DIV) step();
        end

        $display("Everything OK");
        $finish;
    end

endmodule

/* filelist.f */
fm_pkg.sv
op_freq_if.sv
op_freq_regs.sv
sample_strobe_gen.sv
calc_phase_inc.sv
phase_acc.sv
fm_phase_top.sv
tb_fm_phase.sv
